// ==== files.f ====
+incdir+source
source/retire_pkg.sv
source/rob_retire_if.sv
source/reorder_buffer.sv
source/stage_rt.sv
source/arch_regfile.sv
source/retire_top.sv
verif/retire_checker.sv
verif/retire_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the retire testbench with verilator, run it, then scan the log
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f files.f --top-module retire_tb \
    -o retire_sim \
    && ./obj_dir/retire_sim 2>&1 | tee sim.log \
    || { echo "build or simulation error"; exit 1; }

grep -q "TEST FAIL" sim.log && { echo "simulation failed"; exit 1; } || echo "simulation passed"

// ==== source/arch_regfile.sv ====
////////////////////////////////////////////////////////////////////////////
// architectural register file
// written by the retire stage, x0 hardwired to zero, one async read port
////////////////////////////////////////////////////////////////////////////

`include "retire_settings.svh"

module arch_regfile (
    input  logic             clock,
    input  logic             reset,
    input  logic             write_enable,
    input  logic [4:0]       write_index,
    input  logic [`XLEN-1:0] write_data,
    input  logic [4:0]       read_index,
    output logic [`XLEN-1:0] read_data
);

    logic [`XLEN-1:0] regs [`NUM_REGS];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `NUM_REGS; i++)
                regs[i] <= '0;
        end else if (write_enable && (write_index != 5'd0)) begin  // x0 never written
            regs[write_index] <= write_data;
        end
    end

    // combinational read, no bypass from the write port
    assign read_data = (read_index == 5'd0) ? '0 : regs[read_index];

endmodule

// ==== source/reorder_buffer.sv ====
////////////////////////////////////////////////////////////////////////////
// reorder buffer
// circular buffer: tags handed out in program order at dispatch,
// results written back by tag in any order, head offered to retire,
// whole buffer emptied on the retire flush strobe
////////////////////////////////////////////////////////////////////////////

`include "retire_settings.svh"

module reorder_buffer import retire_pkg::*; (
    input  logic                 clock,
    input  logic                 reset,
    // dispatch, in order
    input  logic                 dispatch_valid,
    input  instr_kind_t          dispatch_kind,
    input  logic [4:0]           dispatch_dest,
    input  logic [`XLEN-1:0]     dispatch_npc,
    output logic [`TAG_BITS-1:0] dispatch_tag,
    output logic                 rob_full,
    // completion, by tag
    input  logic                 complete_valid,
    input  logic [`TAG_BITS-1:0] complete_tag,
    input  logic [`XLEN-1:0]     complete_value,
    input  logic                 complete_take_branch,
    // head towards retire
    rob_retire_if.rob            retire
);

    localparam int PTR_BITS = $clog2(`ROB_DEPTH);
    localparam int CNT_BITS = $clog2(`ROB_DEPTH + 1);

    logic [PTR_BITS-1:0]   head;        // oldest entry
    logic [PTR_BITS-1:0]   tail;        // next free slot
    logic [CNT_BITS-1:0]   count;
    logic [`ROB_DEPTH-1:0] occupied;
    logic [`ROB_DEPTH-1:0] completed;

    // entry payload
    logic [`XLEN-1:0] value_mem [`ROB_DEPTH];
    logic             taken_mem [`ROB_DEPTH];
    logic [4:0]       dest_mem  [`ROB_DEPTH];
    logic [`XLEN-1:0] npc_mem   [`ROB_DEPTH];
    instr_kind_t      kind_mem  [`ROB_DEPTH];

    logic                push;          // allocate at tail
    logic                pop;           // head leaves to retire
    logic                complete_in_range;
    logic                complete_hit;  // completion lands on a live entry
    logic [PTR_BITS-1:0] complete_idx;

    // wrap for any depth, not only powers of two
    function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
        return (ptr == PTR_BITS'(`ROB_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign rob_full     = (count == CNT_BITS'(`ROB_DEPTH));
    assign dispatch_tag = `TAG_BITS'(tail);  // tag is the slot index

    assign push = dispatch_valid && !rob_full && !retire.clear_is;
    assign pop  = retire.rob_valid && retire.rob_ready;

    assign complete_idx      = complete_tag[PTR_BITS-1:0];
    assign complete_in_range = (complete_tag < `TAG_BITS'(`ROB_DEPTH));
    assign complete_hit      = complete_valid && !retire.clear_is && complete_in_range
                               && occupied[complete_idx];

    // head offer
    assign retire.rob_valid = occupied[head];
    assign retire.rob_ready = completed[head];
    assign retire.packet    = '{value:       value_mem[head],
                                dest_reg:    dest_mem[head],
                                tag:         `TAG_BITS'(head),
                                npc:         npc_mem[head],
                                kind:        kind_mem[head],
                                take_branch: taken_mem[head]};

    ////////////////////////////////////////////////////////////////////////////
    // control state
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset || retire.clear_is) begin  // flush drops every entry
            head      <= '0;
            tail      <= '0;
            count     <= '0;
            occupied  <= '0;
            completed <= '0;
        end else begin
            if (push) begin
                occupied[tail]  <= 1'b1;
                completed[tail] <= 1'b0;
                tail            <= next_ptr(tail);
            end
            if (complete_hit)
                completed[complete_idx] <= 1'b1;
            if (pop) begin                   // never same slot as push
                occupied[head]  <= 1'b0;
                completed[head] <= 1'b0;
                head            <= next_ptr(head);
            end
            count <= count + CNT_BITS'(push) - CNT_BITS'(pop);
        end
    end

    // payload, written at dispatch and at completion
    always_ff @(posedge clock) begin
        if (push) begin
            kind_mem[tail] <= dispatch_kind;
            dest_mem[tail] <= dispatch_dest;
            npc_mem[tail]  <= dispatch_npc;
        end
        if (complete_hit) begin
            value_mem[complete_idx] <= complete_value;
            taken_mem[complete_idx] <= complete_take_branch;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////

    // execution side must not complete a tag the rob never handed out
    a_complete_live: assert property (@(posedge clock) disable iff (reset)
        complete_valid && !retire.clear_is |-> complete_in_range && occupied[complete_idx]);

    a_count_bound: assert property (@(posedge clock) disable iff (reset)
        count <= CNT_BITS'(`ROB_DEPTH));

endmodule

// ==== source/retire_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// retire package
// instruction kind set at dispatch and the head packet handed from the
// reorder buffer to the retire stage
////////////////////////////////////////////////////////////////////////////

`include "retire_settings.svh"

package retire_pkg;

    // decides what the retire stage does with an entry
    typedef enum logic [2:0] {
        KIND_ALU     = 3'd0,   // plain register write
        KIND_BRANCH  = 3'd1,   // may redirect, writes npc when taken
        KIND_STORE   = 3'd2,   // reported to lsq, no register write
        KIND_CSR     = 3'd3,
        KIND_HALT    = 3'd4,
        KIND_ILLEGAL = 3'd5
    } instr_kind_t;

    // head entry as seen by retire
    typedef struct packed {
        logic [`XLEN-1:0]     value;        // result, or target for branches
        logic [4:0]           dest_reg;
        logic [`TAG_BITS-1:0] tag;
        logic [`XLEN-1:0]     npc;          // return address for taken branch
        instr_kind_t          kind;
        logic                 take_branch;  // only means something for branches
    } rob_retire_packet_t;

endpackage

// ==== source/retire_settings.svh ====
////////////////////////////////////////////////////////////////////////////
// retire settings
// widths and sizes shared by the reorder buffer, the retire stage and
// the architectural register file
////////////////////////////////////////////////////////////////////////////

`ifndef RETIRE_SETTINGS_SVH
`define RETIRE_SETTINGS_SVH

`define XLEN      32   // data and address width
`define TAG_BITS  5    // reorder buffer tag width
`define ROB_DEPTH 16   // rob entries, at most 2**TAG_BITS
`define NUM_REGS  32   // architectural registers

// tag space must cover every rob slot

`endif

// ==== source/retire_top.sv ====
////////////////////////////////////////////////////////////////////////////
// retire top
// reorder buffer, retire stage and architectural register file of the
// commit end, on plain ports
////////////////////////////////////////////////////////////////////////////

`include "retire_settings.svh"

module retire_top import retire_pkg::*; (
    input  logic                 clock,
    input  logic                 reset,
    // dispatch
    input  logic                 dispatch_valid,
    input  instr_kind_t          dispatch_kind,
    input  logic [4:0]           dispatch_dest,
    input  logic [`XLEN-1:0]     dispatch_npc,
    output logic [`TAG_BITS-1:0] dispatch_tag,
    output logic                 rob_full,
    // completion
    input  logic                 complete_valid,
    input  logic [`TAG_BITS-1:0] complete_tag,
    input  logic [`XLEN-1:0]     complete_value,
    input  logic                 complete_take_branch,
    // register read port
    input  logic [4:0]           read_index,
    output logic [`XLEN-1:0]     read_data,
    // retire
    output logic [`XLEN-1:0]     retire_value,
    output logic [4:0]           retire_dest,
    output logic                 retire_valid,
    output logic [`TAG_BITS-1:0] retire_tag,
    output logic                 mem_valid,
    output logic [`TAG_BITS-1:0] mem_tag,
    output logic                 halt,
    output logic                 illegal,
    output logic                 csr_op,
    output logic [`XLEN-1:0]     npc,
    output logic                 take_branch,
    output logic [`XLEN-1:0]     new_addr,
    output logic                 clear_is,
    output logic                 stall_if,
    output logic                 clear_lsq
);

    rob_retire_if rob_rt_bus ();

    reorder_buffer reorder_buffer_inst (
        .clock                (clock),
        .reset                (reset),
        .dispatch_valid       (dispatch_valid),
        .dispatch_kind        (dispatch_kind),
        .dispatch_dest        (dispatch_dest),
        .dispatch_npc         (dispatch_npc),
        .dispatch_tag         (dispatch_tag),
        .rob_full             (rob_full),
        .complete_valid       (complete_valid),
        .complete_tag         (complete_tag),
        .complete_value       (complete_value),
        .complete_take_branch (complete_take_branch),
        .retire               (rob_rt_bus.rob)
    );

    stage_rt stage_rt_inst (
        .clock        (clock),
        .reset        (reset),
        .retire       (rob_rt_bus.rt),
        .retire_value (retire_value),
        .retire_dest  (retire_dest),
        .retire_valid (retire_valid),
        .retire_tag   (retire_tag),
        .mem_valid    (mem_valid),
        .mem_tag      (mem_tag),
        .halt         (halt),
        .illegal      (illegal),
        .csr_op       (csr_op),
        .npc          (npc),
        .take_branch  (take_branch),
        .new_addr     (new_addr),
        .clear_is     (clear_is),
        .stall_if     (stall_if),
        .clear_lsq    (clear_lsq)
    );

    // commit lands in the register file one edge after retire_valid
    arch_regfile arch_regfile_inst (
        .clock        (clock),
        .reset        (reset),
        .write_enable (retire_valid),
        .write_index  (retire_dest),
        .write_data   (retire_value),
        .read_index   (read_index),
        .read_data    (read_data)
    );

endmodule

// ==== source/rob_retire_if.sv ====
////////////////////////////////////////////////////////////////////////////
// rob to retire link
// head packet with its valid and ready levels going forward, flush
// strobe coming back from the retire stage
////////////////////////////////////////////////////////////////////////////

interface rob_retire_if import retire_pkg::*;;

    rob_retire_packet_t packet;     // current head entry
    logic               rob_valid;  // head slot occupied
    logic               rob_ready;  // head slot completed
    logic               clear_is;   // taken branch flush, one cycle

    // head retires on any edge with rob_valid && rob_ready, no back-pressure

    modport rob (output packet, output rob_valid, output rob_ready,
                 input clear_is);

    modport rt (input packet, input rob_valid, input rob_ready,
                output clear_is);

endinterface

// ==== source/stage_rt.sv ====
////////////////////////////////////////////////////////////////////////////
// retire stage
// commits the rob head one per cycle: register write, store report to
// the lsq, status flags, and redirect plus flush on a taken branch
////////////////////////////////////////////////////////////////////////////

`include "retire_settings.svh"

module stage_rt import retire_pkg::*; (
    input  logic                 clock,
    input  logic                 reset,
    rob_retire_if.rt             retire,     // head from rob, flush back
    // register file commit
    output logic [`XLEN-1:0]     retire_value,
    output logic [4:0]           retire_dest,
    output logic                 retire_valid,
    output logic [`TAG_BITS-1:0] retire_tag,
    // lsq
    output logic                 mem_valid,
    output logic [`TAG_BITS-1:0] mem_tag,
    // status
    output logic                 halt,
    output logic                 illegal,
    output logic                 csr_op,
    output logic [`XLEN-1:0]     npc,
    // redirect
    output logic                 take_branch,
    output logic [`XLEN-1:0]     new_addr,
    output logic                 clear_is,
    output logic                 stall_if,
    output logic                 clear_lsq
);

    rob_retire_packet_t head;    // packet on offer
    logic               commit;  // head retires this edge
    logic               is_store;
    logic               taken;   // branch resolved taken, always a mispredict
    logic               flush;   // one cycle after a taken branch

    assign head     = retire.packet;
    // anything popped during flush is younger than the branch, drop it
    assign commit   = retire.rob_valid && retire.rob_ready && !flush;
    assign is_store = (head.kind == KIND_STORE);
    assign taken    = (head.kind == KIND_BRANCH) && head.take_branch;

    ////////////////////////////////////////////////////////////////////////////
    // commit registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset || !commit) begin  // idle cycle, all outputs back to zero
            retire_value <= '0;
            retire_dest  <= '0;
            retire_valid <= 1'b0;
            retire_tag   <= '0;
            mem_valid    <= 1'b0;
            mem_tag      <= '0;
            halt         <= 1'b0;
            illegal      <= 1'b0;
            csr_op       <= 1'b0;
            npc          <= '0;
            new_addr     <= '0;
            flush        <= 1'b0;
        end else begin
            // taken branch links npc into dest, like jal
            retire_value <= taken ? head.npc : head.value;
            retire_dest  <= head.dest_reg;
            retire_valid <= !is_store;
            retire_tag   <= head.tag;
            mem_valid    <= is_store;
            mem_tag      <= is_store ? head.tag : '0;
            halt         <= (head.kind == KIND_HALT);
            illegal      <= (head.kind == KIND_ILLEGAL);
            csr_op       <= (head.kind == KIND_CSR);
            npc          <= head.npc;
            new_addr     <= taken ? head.value : '0;  // completed value is the target
            flush        <= taken;
        end
    end

    // predictor is fixed not-taken, so every taken branch flushes
    assign take_branch     = flush;
    assign clear_is        = flush;
    assign stall_if        = flush;
    assign clear_lsq       = flush;
    assign retire.clear_is = flush;  // empties rob on the next edge

    // rob must be empty after a flush, so no back-to-back redirect
    a_flush_empties_rob: assert property (@(posedge clock) disable iff (reset)
        clear_is |=> !retire.rob_valid);

endmodule

// ==== verif/retire_checker.sv ====
////////////////////////////////////////////////////////////////////////////
// retire checker
// compares each retire record on the DUT ports with the expected queue
// filled by the testbench, watches the redirect strobes, counts errors
////////////////////////////////////////////////////////////////////////////

`include "retire_settings.svh"

module retire_checker (
    input logic                 clock,
    input logic                 reset,
    input logic [`XLEN-1:0]     retire_value, new_addr, npc,
    input logic [4:0]           retire_dest,
    input logic [`TAG_BITS-1:0] retire_tag, mem_tag,
    input logic                 retire_valid, mem_valid, halt, illegal, csr_op,
    input logic                 take_branch, clear_is, stall_if, clear_lsq
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [116:0] expected_q [$];       // retire records in program order
    logic [116:0] actual;               // same layout as the records
    logic [116:0] expected_rec;         // record popped this cycle
    logic         redirect_due;         // popped record is a taken branch
    string        test_name = "none";
    int           test_errors = 0;
    int           error_count = 0;
    int           check_count = 0;
    int           test_count = 0;
    int           pending = 0;          // records not yet seen

    assign actual = {retire_value, retire_dest, retire_tag, retire_valid, mem_valid,
                     mem_tag, halt, illegal, csr_op, take_branch, new_addr, npc};

    task automatic add_expected(input logic [116:0] rec);
        expected_q.push_back(rec);
        pending++;
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        test_count++;
        $display("test %s %s, %0d errors", test_name,
                 (test_errors == 0) ? "ok" : "failed", test_errors);
    endtask

    task automatic check_value(input logic [116:0] expected, input logic [116:0] got);
        check_count++;
        if (got !== expected) begin
            $display("mismatch %s expected %h actual %h", test_name, expected, got);
            test_errors++;
            error_count++;
        end
    endtask

    task automatic report_failure(input string msg);
        $display("error in %s: %s", test_name, msg);
        test_errors++;
        error_count++;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // sampled on the falling edge, half a cycle after the outputs settle
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clock) begin
        if (!reset) begin
            redirect_due = 1'b0;
            if (retire_valid || mem_valid) begin
                if (expected_q.size() == 0) begin
                    report_failure("retire record with nothing expected");
                end else begin
                    expected_rec = expected_q.pop_front();
                    redirect_due = expected_rec[64];  // take_branch field
                    check_value(expected_rec, actual);
                    pending--;
                end
            end
            // redirect and all three flush strobes only with a taken branch
            if ({take_branch, clear_is, stall_if, clear_lsq} !== {4{redirect_due}})
                report_failure("redirect strobes do not match the retired record");
        end
    end

endmodule

// ==== verif/retire_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// retire testbench
// random program batches through dispatch and out-of-order completion,
// reference model of the commit order and the register file
////////////////////////////////////////////////////////////////////////////

`include "retire_settings.svh"

module retire_tb import retire_pkg::*;;
    timeunit 1ns;
    timeprecision 100ps;

    logic                 clock = 1'b0;
    logic                 reset;
    logic                 dispatch_valid, rob_full;
    instr_kind_t          dispatch_kind;
    logic [4:0]           dispatch_dest, retire_dest, read_index;
    logic [`XLEN-1:0]     dispatch_npc, complete_value, read_data;
    logic [`XLEN-1:0]     retire_value, npc, new_addr;
    logic [`TAG_BITS-1:0] dispatch_tag, complete_tag, retire_tag, mem_tag;
    logic                 complete_valid, complete_take_branch;
    logic                 retire_valid, mem_valid, halt, illegal, csr_op;
    logic                 take_branch, clear_is, stall_if, clear_lsq;

    // current batch, index is program order
    instr_kind_t          b_kind  [`ROB_DEPTH];
    logic [4:0]           b_dest  [`ROB_DEPTH];
    logic [`XLEN-1:0]     b_npc   [`ROB_DEPTH];
    logic [`XLEN-1:0]     b_value [`ROB_DEPTH];  // result, or target for branches
    logic                 b_taken [`ROB_DEPTH];
    logic [`TAG_BITS-1:0] b_tag   [`ROB_DEPTH];
    logic [`XLEN-1:0]     reg_model [`NUM_REGS];
    logic [116:0]         batch_records [$];
    int                   model_tail = 0;        // next tag the rob hands out
    instr_kind_t          kind_pool [6] = '{KIND_ALU, KIND_CSR, KIND_HALT,
                                            KIND_ILLEGAL, KIND_STORE, KIND_BRANCH};

    always #2 clock = ~clock;  // 4 ns period

    retire_top retire_top_inst (.*);
    retire_checker checker_inst (.*);

    // expected records and register effects of a batch, program order
    function automatic void predict_batch(input int n);
        logic             redirect;
        logic             is_store;
        logic             taken;
        logic [`XLEN-1:0] result;
        redirect = 1'b0;
        batch_records.delete();
        for (int i = 0; i < n; i++) begin
            if (!redirect) begin  // younger than a taken branch, never retires
                is_store = (b_kind[i] == KIND_STORE);
                taken    = (b_kind[i] == KIND_BRANCH) && b_taken[i];
                result   = taken ? b_npc[i] : b_value[i];  // link address
                batch_records.push_back({result, b_dest[i], b_tag[i], !is_store, is_store,
                    is_store ? b_tag[i] : 5'd0, b_kind[i] == KIND_HALT,
                    b_kind[i] == KIND_ILLEGAL, b_kind[i] == KIND_CSR, taken,
                    taken ? b_value[i] : 32'd0, b_npc[i]});
                if (!is_store && b_dest[i] != 5'd0)
                    reg_model[b_dest[i]] = result;
                if (taken) begin
                    redirect   = 1'b1;
                    model_tail = 0;  // flush rewinds the rob pointers
                end
            end
        end
    endfunction

    task automatic make_batch(input int mode, input int n);
        for (int i = 0; i < n; i++) begin
            b_kind[i] = kind_pool[$urandom % (4 + mode)];  // mode widens the kind set
            if (mode == 2 && i == n / 2)
                b_kind[i] = KIND_BRANCH;
            b_dest[i]  = 5'($urandom);
            b_npc[i]   = $urandom & 32'hffff_fffc;
            b_value[i] = $urandom;
            b_taken[i] = (b_kind[i] == KIND_BRANCH) && ($urandom % 2 == 1);
            b_tag[i]   = `TAG_BITS'(model_tail);
            model_tail = (model_tail + 1) % `ROB_DEPTH;
        end
        predict_batch(n);
        foreach (batch_records[r])
            checker_inst.add_expected(batch_records[r]);
    endtask

    task automatic dispatch_batch(input int count);
        int k;
        for (int i = 0; i < count; i++) begin
            @(posedge clock);
            #0.5;
            k = (i < `ROB_DEPTH) ? i : 0;  // a full rob keeps its tail
            checker_inst.check_value(117'(i >= `ROB_DEPTH), 117'(rob_full));
            checker_inst.check_value(117'(b_tag[k]), 117'(dispatch_tag));
            dispatch_valid = 1'b1;
            dispatch_kind  = b_kind[i % `ROB_DEPTH];
            dispatch_dest  = b_dest[i % `ROB_DEPTH];
            dispatch_npc   = b_npc[i % `ROB_DEPTH];
        end
        @(posedge clock);
        #0.5;
        dispatch_valid = 1'b0;
    endtask

    task automatic complete_batch(input int n);
        int order [`ROB_DEPTH];
        int j;
        int tmp;
        for (int i = 0; i < n; i++)
            order[i] = i;
        for (int i = n - 1; i > 0; i--) begin  // shuffle
            j        = $urandom % (i + 1);
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        // stop once a flush is seen, the rest of the batch is gone
        for (int i = 0; i < n && !clear_is; i++) begin
            complete_valid       = 1'b1;
            complete_tag         = b_tag[order[i]];
            complete_value       = b_value[order[i]];
            complete_take_branch = b_taken[order[i]];
            @(posedge clock);
            #0.5;
        end
        complete_valid = 1'b0;
    endtask

    task automatic wait_drained();
        int cycles;
        for (cycles = 0; cycles < 200; cycles++) begin
            if (checker_inst.pending == 0 && !clear_is)
                break;
            @(posedge clock);
            #0.5;
        end
        if (cycles == 200)
            checker_inst.report_failure("timeout, expected retire records never arrived");
    endtask

    task automatic run_batch(input int mode);
        int n;
        n = 1 + ($urandom % `ROB_DEPTH);
        make_batch(mode, n);
        dispatch_batch(n);
        complete_batch(n);
        wait_drained();
    endtask

    initial begin
        void'($urandom(18788));
        reset                = 1'b1;
        dispatch_valid       = 1'b0;
        dispatch_kind        = KIND_ALU;
        dispatch_dest        = '0;
        dispatch_npc         = '0;
        complete_valid       = 1'b0;
        complete_tag         = '0;
        complete_value       = '0;
        complete_take_branch = 1'b0;
        read_index           = '0;
        foreach (reg_model[i])
            reg_model[i] = '0;
        repeat (8) @(posedge clock);
        #0.5;
        reset = 1'b0;

        checker_inst.begin_test("reset_idle");
        for (int i = 0; i < `NUM_REGS; i++) begin
            @(posedge clock);
            #0.5;
            read_index = 5'(i);
            @(negedge clock);
            checker_inst.check_value('0, checker_inst.actual);
            checker_inst.check_value('0, 117'({rob_full, dispatch_tag, read_data}));
        end
        checker_inst.end_test();

        checker_inst.begin_test("in_order_retire");
        repeat (4) run_batch(0);
        checker_inst.end_test();
        checker_inst.begin_test("store_report");
        repeat (4) run_batch(1);
        checker_inst.end_test();
        checker_inst.begin_test("branch_redirect");
        repeat (6) run_batch(2);
        checker_inst.end_test();

        checker_inst.begin_test("rob_full");
        make_batch(0, `ROB_DEPTH);
        dispatch_batch(`ROB_DEPTH + 3);  // three extra while full
        complete_batch(`ROB_DEPTH);
        wait_drained();
        repeat (5) @(posedge clock);     // room for any stray retire
        checker_inst.end_test();

        checker_inst.begin_test("register_readback");
        for (int i = 0; i < `NUM_REGS; i++) begin
            @(posedge clock);
            #0.5;
            read_index = 5'(i);
            @(negedge clock);
            checker_inst.check_value(117'(reg_model[i]), 117'(read_data));
        end
        checker_inst.end_test();

        $display("tests %0d checks %0d errors %0d", checker_inst.test_count,
                 checker_inst.check_count, checker_inst.error_count);
        if (checker_inst.error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
